/* files.f */
+incdir+hdl
hdl/psram_pkg.sv
hdl/req_fifo.sv
hdl/req_dispatch.sv
hdl/qspi_ctrl.sv
hdl/psram_subsys.sv
dv/psram_model.sv
dv/psram_subsys_chk.sv
dv/tb_psram_subsys.sv

/* Makefile */
# Verilator build and run for the PSRAM memory port testbench.

OBJ = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_psram_subsys \
		-f files.f --Mdir $(OBJ) -o sim_tb

run: compile
	./$(OBJ)/sim_tb | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

/* dv/tb_psram_subsys.sv */
/*
 * Testbench for the PSRAM memory port. Runs a stimulus table of writes
 * and reads against a behavioral PSRAM, predicts read words from a byte
 * reference memory, then checks back-pressure on both FIFOs.
 */
`timescale 1ns/10ps
`default_nettype none
`include "psram_defs.svh"

module tb_psram_subsys import psram_pkg::*; ();

  localparam int WAIT_LIMIT = 2000;
  localparam int NUM_ROWS   = 23;

  typedef struct packed {
    logic [3:0] test;
    logic       write;
    addr_t      addr;
    word_t      data;
    strb_t      strb;
  } row_t;

  // a write row with data 0 takes its data from the LFSR.
  // the mixed rows use one word offset on every chip, so a wrong cs shows up.
  row_t stim [NUM_ROWS] = '{
    '{4'd2, 1'b1, 23'h000010, 32'h00000000, 4'b1111},
    '{4'd2, 1'b0, 23'h000010, 32'h00000000, 4'b0000},
    '{4'd3, 1'b1, 23'h000020, 32'h11223344, 4'b1111},
    '{4'd3, 1'b1, 23'h000020, 32'h00000000, 4'b0001},
    '{4'd3, 1'b1, 23'h000020, 32'h00000000, 4'b0010},
    '{4'd3, 1'b1, 23'h000020, 32'h00000000, 4'b0100},
    '{4'd3, 1'b1, 23'h000020, 32'h00000000, 4'b1000},
    '{4'd3, 1'b0, 23'h000020, 32'h00000000, 4'b0000},
    '{4'd3, 1'b1, 23'h000020, 32'h00000000, 4'b0011},
    '{4'd3, 1'b1, 23'h000020, 32'h00000000, 4'b1100},
    '{4'd3, 1'b0, 23'h000020, 32'h00000000, 4'b0000},
    '{4'd3, 1'b1, 23'h000020, 32'h00000000, 4'b0101},
    '{4'd3, 1'b0, 23'h000020, 32'h00000000, 4'b0000},
    '{4'd4, 1'b1, 23'h200040, 32'h00000000, 4'b1111},
    '{4'd4, 1'b1, 23'h600040, 32'h00000000, 4'b1111},
    '{4'd4, 1'b0, 23'h200040, 32'h00000000, 4'b0000},
    '{4'd4, 1'b1, 23'h400040, 32'h00000000, 4'b0011},
    '{4'd4, 1'b0, 23'h600040, 32'h00000000, 4'b0000},
    '{4'd4, 1'b1, 23'h200040, 32'h00000000, 4'b1000},
    '{4'd4, 1'b0, 23'h200040, 32'h00000000, 4'b0000},
    '{4'd4, 1'b0, 23'h400040, 32'h00000000, 4'b0000},
    '{4'd4, 1'b1, 23'h000040, 32'h00000000, 4'b1111},
    '{4'd4, 1'b0, 23'h600040, 32'h00000000, 4'b0000}
  };

  logic        clk = 1'b0;
  logic        resetn = 1'b0;
  logic        req_push = 1'b0;
  addr_t       req_addr = '0;
  word_t       req_wdata = '0;
  strb_t       req_wstrb = '0;
  logic        rsp_pop = 1'b0;
  wire         req_full;
  wire word_t  rsp_rdata;
  wire         rsp_empty;
  wire         cen;
  wire         sclk;
  wire [1:0]   cs;
  wire         sio0;
  wire         sio1;
  wire         sio2;
  wire         sio3;

  logic [7:0]  ref_mem [int];
  word_t       exp_q [$];
  logic [31:0] lfsr_state = 32'd88;
  logic        full_seen = 1'b0;
  int          errors = 0;
  int          test_start = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;

  always #5 clk = ~clk;

  psram_subsys #(.QUAD_MODE(1'b1)) i_psram_subsys (
    .clk (clk), .resetn (resetn), .req_push (req_push), .req_addr (req_addr),
    .req_wdata (req_wdata), .req_wstrb (req_wstrb), .req_full (req_full),
    .rsp_pop (rsp_pop), .rsp_rdata (rsp_rdata), .rsp_empty (rsp_empty),
    .cen (cen), .sclk (sclk), .cs (cs),
    .sio0 (sio0), .sio1 (sio1), .sio2 (sio2), .sio3 (sio3)
  );

  psram_model i_psram_model (
    .cen (cen), .sclk (sclk), .cs (cs),
    .sio0 (sio0), .sio1 (sio1), .sio2 (sio2), .sio3 (sio3)
  );

  // ############################################################
  // reference model and random data
  // ############################################################

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic next_rand_word(output word_t w);
    for (int b = 0; b < 32; b++) begin
      w[b]       = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  function automatic int ref_key(input addr_t a, input int i);
    return int'({a, 2'(i)});
  endfunction

  // byte 0 of a word sits at the top, as it goes first on the wire.
  task automatic ref_write(input addr_t a, input word_t d, input strb_t s);
    logic legal;
    legal = (s inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100});
    for (int j = 0; j < 4; j++) begin
      if (!legal || s[j]) begin
        ref_mem[ref_key(a, 3 - j)] = d[8*j +: 8];
      end
    end
  endtask

  function automatic word_t ref_read(input addr_t a);
    word_t w;
    w = '0;
    for (int i = 0; i < 4; i++) begin
      if (ref_mem.exists(ref_key(a, i))) begin
        w[31-8*i -: 8] = ref_mem[ref_key(a, i)];
      end
    end
    return w;
  endfunction

  // ############################################################
  // host side tasks and checks
  // ############################################################

  task automatic abort_run(input string what);
    $display("timeout while waiting for %s", what);
    $display("sim failed");
    $finish;
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("Fail %0t: %s", $time, what);
      errors++;
    end
  endtask

  task automatic push_req(input addr_t a, input word_t d, input strb_t s);
    int n;
    n = 0;
    @(negedge clk);
    while (req_full) begin
      full_seen = 1'b1;
      n++;
      if (n > WAIT_LIMIT) abort_run("req_full to fall");
      @(negedge clk);
    end
    @(posedge clk);
    req_push  <= 1'b1;
    req_addr  <= a;
    req_wdata <= d;
    req_wstrb <= s;
    @(posedge clk);
    req_push  <= 1'b0;
  endtask

  task automatic pop_check();
    int    n;
    word_t got;
    word_t exp;
    n = 0;
    @(negedge clk);
    while (rsp_empty) begin
      n++;
      if (n > WAIT_LIMIT) abort_run("a read response");
      @(negedge clk);
    end
    got = rsp_rdata;
    @(posedge clk);
    rsp_pop <= 1'b1;
    @(posedge clk);
    rsp_pop <= 1'b0;
    exp = exp_q.pop_front();
    assert (got === exp) else begin
      $display("Fail %0t: read word %h, expected %h", $time, got, exp);
      errors++;
    end
  endtask

  task automatic issue_read(input addr_t a);
    exp_q.push_back(ref_read(a));
    push_req(a, '0, '0);
  endtask

  task automatic end_test(input string name);
    if (errors == test_start) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - test_start);
    end
    test_start = errors;
  endtask

  function automatic string test_name(input logic [3:0] id);
    case (id)
      4'd2:    return "word write and readback";
      4'd3:    return "byte and halfword merge";
      default: return "mixed sequence on all chips";
    endcase
  endfunction

  // ############################################################
  // test sequence
  // ############################################################

  initial begin
    word_t wd;
    addr_t a;
    int    n;

    repeat (2) @(posedge clk);
    resetn <= 1'b1;
    @(negedge clk);
    check_true(cen, "cen high after reset");
    check_true(sclk, "sclk high after reset");
    check_true(!req_full, "req_full low after reset");
    check_true(rsp_empty, "rsp_empty high after reset");
    end_test("reset state");

    for (int i = 0; i < NUM_ROWS; i++) begin
      if (stim[i].write) begin
        wd = stim[i].data;
        if (wd == '0) next_rand_word(wd);
        ref_write(stim[i].addr, wd, stim[i].strb);
        push_req(stim[i].addr, wd, stim[i].strb);
      end else begin
        issue_read(stim[i].addr);
        pop_check();
      end
      if (i == NUM_ROWS - 1 || stim[i+1].test != stim[i].test) begin
        end_test(test_name(stim[i].test));
      end
    end

    // six writes back to back outrun the request FIFO.
    full_seen = 1'b0;
    for (int i = 0; i < 6; i++) begin
      a = 23'h000100 + 23'(i);
      next_rand_word(wd);
      ref_write(a, wd, 4'b1111);
      push_req(a, wd, 4'b1111);
    end
    check_true(full_seen, "req_full seen during write burst");
    for (int i = 0; i < 6; i++) begin
      issue_read(23'h000100 + 23'(i));
      pop_check();
    end
    end_test("write burst with req_full");

    // six reads fill the response FIFO before anything is popped.
    for (int i = 0; i < 6; i++) begin
      issue_read(23'h000100 + 23'(i));
    end
    n = 0;
    @(negedge clk);
    while (rsp_empty) begin
      n++;
      if (n > WAIT_LIMIT) abort_run("responses of the read burst");
      @(negedge clk);
    end
    for (int i = 0; i < 6; i++) begin
      pop_check();
    end
    @(negedge clk);
    check_true(rsp_empty, "rsp_empty high after last pop");
    end_test("read burst with rsp back-pressure");

    $display("tests ok %0d, tests failing %0d, check errors %0d",
             tests_ok, tests_bad, errors);
    if (errors == 0 && tests_bad == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/psram_subsys_chk.sv */
/*
 * Concurrent assertions on the PSRAM memory port pins and the response
 * FIFO, bound into every psram_subsys instance.
 */
`timescale 1ns/10ps
`default_nettype none

module psram_subsys_chk (
  input wire clk,
  input wire resetn,
  input wire cen,
  input wire sclk,
  input wire rsp_empty,
  input wire rsp_push
);

  cen_high_in_reset: assert property (@(posedge clk) !resetn |=> cen)
    else $error("cen low while in reset");

  // the serial clock is parked whenever the chip is deselected.
  sclk_parked: assert property (@(posedge clk) disable iff (!resetn)
    ($past(cen) && cen) |-> $stable(sclk))
    else $error("sclk toggled while cen high");

  rsp_from_read: assert property (@(posedge clk) disable iff (!resetn)
    $fell(rsp_empty) |-> $past(rsp_push))
    else $error("response appeared without a read push");

endmodule

bind psram_subsys psram_subsys_chk i_psram_subsys_chk (
  .clk       (clk),
  .resetn    (resetn),
  .cen       (cen),
  .sclk      (sclk),
  .rsp_empty (rsp_empty),
  .rsp_push  (rsp_push)
);

`default_nettype wire

/* dv/psram_model.sv */
/*
 * Behavioral quad PSRAM for simulation. Answers quad write (0x38) and
 * quad read (0xEB, six wait clocks) from a byte memory keyed by chip
 * select and byte address. Attach it to the controller pins.
 */
`timescale 1ns/10ps
`default_nettype none
`include "psram_defs.svh"

module psram_model (
  input  wire       cen,
  input  wire       sclk,
  input  wire [1:0] cs,
  inout  wire       sio0,
  inout  wire       sio1,
  inout  wire       sio2,
  inout  wire       sio3
);

  logic [7:0]  mem [int];
  logic [7:0]  cmd = 8'h00;
  logic [23:0] baddr = 24'h000000;
  logic [3:0]  nib_hi = 4'h0;
  logic [3:0]  dout = 4'h0;
  logic        drive = 1'b0;
  int          edge_cnt = 0;
  wire  [3:0]  din = {sio3, sio2, sio1, sio0};

  assign sio0 = drive ? dout[0] : 1'bz;
  assign sio1 = drive ? dout[1] : 1'bz;
  assign sio2 = drive ? dout[2] : 1'bz;
  assign sio3 = drive ? dout[3] : 1'bz;

  function automatic int mem_key(input logic [1:0] sel, input logic [23:0] a);
    return int'({sel, a[22:0]});
  endfunction

  // rising edges count through command, address, wait and data phases.
  always @(posedge sclk) begin
    if (!cen) begin
      if (edge_cnt < 8) begin
        cmd = {cmd[6:0], sio0};
      end else if (edge_cnt < 14) begin
        baddr = {baddr[19:0], din};
      end else if (cmd == `CMD_QUAD_WRITE) begin
        if (((edge_cnt - 14) % 2) == 0) begin
          nib_hi = din;
        end else begin
          mem[mem_key(cs, 24'(baddr + 24'((edge_cnt - 14) / 2)))] = {nib_hi, din};
        end
      end
      edge_cnt = edge_cnt + 1;
    end
  end

  // read data is put out after the falling edge, ahead of its rising edge.
  always @(negedge sclk) begin
    int          k;
    logic [23:0] a;
    logic [7:0]  b;
    if (!cen && cmd == `CMD_QUAD_READ && edge_cnt >= 20 && edge_cnt < 28) begin
      k = edge_cnt - 20;
      a = 24'(baddr + 24'(k / 2));
      b = mem.exists(mem_key(cs, a)) ? mem[mem_key(cs, a)] : 8'h00;
      dout  = ((k % 2) == 0) ? b[7:4] : b[3:0];
      drive = 1'b1;
    end else begin
      drive = 1'b0;
    end
  end

  always @(posedge cen) begin
    drive    = 1'b0;
    edge_cnt = 0;
  end

endmodule

`default_nettype wire

/* hdl/psram_subsys.sv */
/*
 * Top level of the PSRAM memory port. Host requests enter a request
 * FIFO, the dispatcher feeds them to the QSPI controller one at a time,
 * and read words come back in order through a response FIFO.
 */
`timescale 1ns/10ps
`default_nettype none
`include "psram_defs.svh"

module psram_subsys import psram_pkg::*; #(
  parameter bit QUAD_MODE = 1'b1
) (
  input  logic       clk,
  input  logic       resetn,
  input  logic       req_push,
  input  addr_t      req_addr,
  input  word_t      req_wdata,
  input  strb_t      req_wstrb,
  output logic       req_full,
  input  logic       rsp_pop,
  output word_t      rsp_rdata,
  output logic       rsp_empty,
  output logic       cen,
  output logic       sclk,
  output logic [1:0] cs,
  inout  wire        sio0,
  inout  wire        sio1,
  inout  wire        sio2,
  inout  wire        sio3
);

  mem_req_t req_in;
  mem_req_t req_head;
  logic     req_empty;
  logic     req_pop;
  logic     rsp_push;
  logic     rsp_full;
  word_t    rsp_data;
  logic     ctrl_valid;
  logic     ctrl_ready;
  addr_t    ctrl_addr;
  word_t    ctrl_wdata;
  strb_t    ctrl_wstrb;
  word_t    ctrl_rdata;

  assign req_in = '{addr: req_addr, wdata: req_wdata, wstrb: req_wstrb};

  req_fifo #(
    .payload_t (mem_req_t),
    .DEPTH     (`REQ_FIFO_DEPTH)
  ) i_req_fifo (
    .clk    (clk),
    .resetn (resetn),
    .push   (req_push),
    .din    (req_in),
    .pop    (req_pop),
    .dout   (req_head),
    .full   (req_full),
    .empty  (req_empty)
  );

  req_fifo #(
    .payload_t (word_t),
    .DEPTH     (`RSP_FIFO_DEPTH)
  ) i_rsp_fifo (
    .clk    (clk),
    .resetn (resetn),
    .push   (rsp_push),
    .din    (rsp_data),
    .pop    (rsp_pop),
    .dout   (rsp_rdata),
    .full   (rsp_full),
    .empty  (rsp_empty)
  );

  req_dispatch i_req_dispatch (
    .clk       (clk),
    .resetn    (resetn),
    .req_empty (req_empty),
    .req_head  (req_head),
    .req_pop   (req_pop),
    .rsp_full  (rsp_full),
    .rsp_push  (rsp_push),
    .rsp_data  (rsp_data),
    .valid     (ctrl_valid),
    .ready     (ctrl_ready),
    .addr      (ctrl_addr),
    .wdata     (ctrl_wdata),
    .wstrb     (ctrl_wstrb),
    .rdata     (ctrl_rdata)
  );

  qspi_ctrl #(
    .QUAD_MODE (QUAD_MODE)
  ) i_qspi_ctrl (
    .clk    (clk),
    .resetn (resetn),
    .valid  (ctrl_valid),
    .ready  (ctrl_ready),
    .addr   (ctrl_addr),
    .wdata  (ctrl_wdata),
    .wstrb  (ctrl_wstrb),
    .rdata  (ctrl_rdata),
    .cen    (cen),
    .sclk   (sclk),
    .cs     (cs),
    .sio0   (sio0),
    .sio1   (sio1),
    .sio2   (sio2),
    .sio3   (sio3)
  );

endmodule

`default_nettype wire

/* hdl/qspi_ctrl.sv */
/*
 * QSPI PSRAM controller. Takes one request over valid/ready, sends the
 * command, the 24-bit byte address, wait clocks for quad reads and then
 * the data. sclk runs at half the clk rate. Narrow writes are aligned so
 * only the strobed bytes go out on the wire.
 */
`timescale 1ns/10ps
`default_nettype none
`include "psram_defs.svh"

module qspi_ctrl import psram_pkg::*; #(
  parameter bit QUAD_MODE = 1'b1
) (
  input  logic       clk,
  input  logic       resetn,
  input  logic       valid,
  output logic       ready,
  input  addr_t      addr,
  input  word_t      wdata,
  input  strb_t      wstrb,
  output word_t      rdata,
  output logic       cen,
  output logic       sclk,
  output logic [1:0] cs,
  inout  wire        sio0,
  inout  wire        sio1,
  inout  wire        sio2,
  inout  wire        sio3
);

  localparam logic [3:0] OE_DATA = QUAD_MODE ? 4'b1111 : 4'b0001;

  qspi_state_t state;
  qspi_state_t state_next;
  word_t       spi_buf;
  word_t       spi_buf_next;
  word_t       rdata_next;
  logic [5:0]  xfer_cnt;
  logic [5:0]  xfer_cnt_next;
  logic        is_quad;
  logic        is_quad_next;
  logic [3:0]  sio_oe;
  logic [3:0]  sio_oe_next;
  logic [3:0]  sio_out;
  logic [3:0]  sio_out_next;
  logic [3:0]  sio_in;
  logic [1:0]  cs_next;
  logic        cen_next;
  logic        sclk_next;
  logic        ready_next;
  logic        write;
  logic [1:0]  byte_offset;
  logic [5:0]  wr_bits;
  word_t       wr_buf;

  assign write = |wstrb;

  assign sio0   = sio_oe[0] ? sio_out[0] : 1'bz;
  assign sio1   = sio_oe[1] ? sio_out[1] : 1'bz;
  assign sio2   = sio_oe[2] ? sio_out[2] : 1'bz;
  assign sio3   = sio_oe[3] ? sio_out[3] : 1'bz;
  assign sio_in = {sio3, sio2, sio1, sio0};

  // ##########################################################
  // write alignment
  // ##########################################################

  // the selected bytes move to the top of the buffer since data is sent
  // msb first. the byte offset goes into the low address bits.
  always_comb begin
    wr_buf      = wdata;
    byte_offset = 2'd0;
    wr_bits     = 6'(`XFER_WORD_BITS);
    case (wstrb)
      4'b0001: begin
        byte_offset   = 2'd3;
        wr_buf[31:24] = wdata[7:0];
        wr_bits       = 6'(`XFER_BYTE_BITS);
      end
      4'b0010: begin
        byte_offset   = 2'd2;
        wr_buf[31:24] = wdata[15:8];
        wr_bits       = 6'(`XFER_BYTE_BITS);
      end
      4'b0100: begin
        byte_offset   = 2'd1;
        wr_buf[31:24] = wdata[23:16];
        wr_bits       = 6'(`XFER_BYTE_BITS);
      end
      4'b1000: begin
        wr_bits = 6'(`XFER_BYTE_BITS);
      end
      4'b0011: begin
        byte_offset   = 2'd2;
        wr_buf[31:16] = wdata[15:0];
        wr_bits       = 6'(`XFER_HALF_BITS);
      end
      4'b1100: begin
        wr_bits = 6'(`XFER_HALF_BITS);
      end
      // full words and every irregular pattern write all four bytes.
      default: begin
        wr_buf = wdata;
      end
    endcase
  end

  // ##########################################################
  // registers
  // ##########################################################

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state    <= QSPI_IDLE;
      cen      <= 1'b1;
      sclk     <= 1'b1;
      cs       <= 2'b00;
      sio_oe   <= 4'b0000;
      is_quad  <= 1'b0;
      xfer_cnt <= '0;
      ready    <= 1'b0;
    end else begin
      state    <= state_next;
      cen      <= cen_next;
      sclk     <= sclk_next;
      cs       <= cs_next;
      sio_oe   <= sio_oe_next;
      is_quad  <= is_quad_next;
      xfer_cnt <= xfer_cnt_next;
      ready    <= ready_next;
    end
  end

  always_ff @(posedge clk) begin
    spi_buf <= spi_buf_next;
    sio_out <= sio_out_next;
    rdata   <= rdata_next;
  end

  // ##########################################################
  // next state
  // ##########################################################

  always_comb begin
    state_next    = state;
    cen_next      = cen;
    sclk_next     = sclk;
    cs_next       = cs;
    sio_oe_next   = sio_oe;
    sio_out_next  = sio_out;
    spi_buf_next  = spi_buf;
    is_quad_next  = is_quad;
    xfer_cnt_next = xfer_cnt;
    ready_next    = ready;
    rdata_next    = rdata;

    if (xfer_cnt != '0) begin
      // a phase is shifting. out on the falling edge, in on the rising one.
      sio_out_next = is_quad ? spi_buf[31:28] : {3'b000, spi_buf[31]};
      if (sclk) begin
        sclk_next = 1'b0;
      end else begin
        sclk_next     = 1'b1;
        spi_buf_next  = is_quad ? {spi_buf[27:0], sio_in} : {spi_buf[30:0], sio_in[1]};
        xfer_cnt_next = is_quad ? xfer_cnt - 6'd4 : xfer_cnt - 6'd1;
      end
    end else begin
      // each state loads the phase that follows the one just shifted.
      case (state)
        QSPI_IDLE: begin
          cen_next    = 1'b1;
          sio_oe_next = 4'b0000;
          if (valid && !ready) begin
            state_next = QSPI_SELECT;
          end else if (!valid) begin
            ready_next = 1'b0;
          end
        end
        QSPI_SELECT: begin
          cs_next     = addr[22:21];
          cen_next    = 1'b0;
          sio_oe_next = 4'b0001;
          state_next  = QSPI_CMD;
        end
        QSPI_CMD: begin
          if (QUAD_MODE) begin
            spi_buf_next[31:24] = write ? `CMD_QUAD_WRITE : `CMD_QUAD_READ;
          end else begin
            spi_buf_next[31:24] = write ? `CMD_WRITE : `CMD_READ;
          end
          xfer_cnt_next = 6'(`XFER_CMD_BITS);
          is_quad_next  = 1'b0;
          state_next    = QSPI_ADDR;
        end
        QSPI_ADDR: begin
          spi_buf_next[31:8] = {1'b0, addr[20:0], write ? byte_offset : 2'b00};
          sio_oe_next        = OE_DATA;
          xfer_cnt_next      = 6'(`XFER_ADDR_BITS);
          is_quad_next       = QUAD_MODE;
          state_next         = (QUAD_MODE && !write) ? QSPI_WAIT : QSPI_XFER;
        end
        QSPI_WAIT: begin
          sio_oe_next   = 4'b0000;
          xfer_cnt_next = 6'(`READ_WAIT_CYCLES);
          is_quad_next  = 1'b0;
          state_next    = QSPI_XFER;
        end
        QSPI_XFER: begin
          is_quad_next = QUAD_MODE;
          if (write) begin
            sio_oe_next   = OE_DATA;
            spi_buf_next  = wr_buf;
            xfer_cnt_next = wr_bits;
          end else begin
            sio_oe_next   = 4'b0000;
            xfer_cnt_next = 6'(`XFER_WORD_BITS);
          end
          state_next = QSPI_DONE;
        end
        QSPI_DONE: begin
          rdata_next = spi_buf;
          ready_next = 1'b1;
          state_next = QSPI_IDLE;
        end
        default: begin
          state_next = QSPI_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/req_dispatch.sv */
/*
 * Moves requests one at a time from the request FIFO to the QSPI
 * controller over a valid/ready level exchange, and pushes each read
 * word into the response FIFO the cycle ready is seen.
 */
`timescale 1ns/10ps
`default_nettype none

module req_dispatch import psram_pkg::*; (
  input  logic     clk,
  input  logic     resetn,
  input  logic     req_empty,
  input  mem_req_t req_head,
  output logic     req_pop,
  input  logic     rsp_full,
  output logic     rsp_push,
  output word_t    rsp_data,
  output logic     valid,
  input  logic     ready,
  output addr_t    addr,
  output word_t    wdata,
  output strb_t    wstrb,
  input  word_t    rdata
);

  typedef enum logic {
    DISP_IDLE,
    DISP_BUSY
  } disp_state_t;

  disp_state_t state;
  logic        start;
  logic        is_read;

  // a read needs a free response slot. writes never produce a response.
  // ready must have dropped from the previous transaction first.
  assign start = (state == DISP_IDLE) && !req_empty && !ready &&
                 ((req_head.wstrb != '0) || !rsp_full);

  assign is_read  = (wstrb == '0);
  assign valid    = (state == DISP_BUSY);
  assign req_pop  = valid && ready;
  assign rsp_push = req_pop && is_read;
  assign rsp_data = rdata;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= DISP_IDLE;
    end else if (start) begin
      state <= DISP_BUSY;
    end else if (req_pop) begin
      state <= DISP_IDLE;
    end
  end

  // request held stable towards the controller while valid is high.
  always_ff @(posedge clk) begin
    if (start) begin
      addr  <= req_head.addr;
      wdata <= req_head.wdata;
      wstrb <= req_head.wstrb;
    end
  end

endmodule

`default_nettype wire

/* hdl/req_fifo.sv */
/*
 * First-word-fall-through FIFO with a configurable payload type.
 * The head entry is always visible on dout while empty is low; pop
 * removes it. Pushes while full and pops while empty are ignored.
 */
`timescale 1ns/10ps
`default_nettype none

module req_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     resetn,
  input  logic     push,
  input  payload_t din,
  input  logic     pop,
  output payload_t dout,
  output logic     full,
  output logic     empty
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_push;
  logic          do_pop;

  // pointers wrap at DEPTH, which need not be a power of two.
  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign full    = (count == CW'(DEPTH));
  assign empty   = (count == '0);
  assign dout    = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

endmodule

`default_nettype wire

/* hdl/psram_pkg.sv */
/*
 * Shared types of the PSRAM memory port: address, data and strobe words,
 * the request record that travels through the request FIFO, and the
 * state encoding of the QSPI controller.
 */
`default_nettype none

package psram_pkg;

  `include "psram_defs.svh"

  // the top 2 bits pick the chip, the low 21 bits the word inside it.
  typedef logic [`PSRAM_ADDR_W-1:0]   addr_t;
  typedef logic [`PSRAM_DATA_W-1:0]   word_t;
  // all strobes low marks a read.
  typedef logic [`PSRAM_DATA_W/8-1:0] strb_t;

  typedef struct packed {
    addr_t addr;
    word_t wdata;
    strb_t wstrb;
  } mem_req_t;

  typedef enum logic [2:0] {
    QSPI_IDLE,
    QSPI_SELECT,
    QSPI_CMD,
    QSPI_ADDR,
    QSPI_WAIT,
    QSPI_XFER,
    QSPI_DONE
  } qspi_state_t;

endpackage

`default_nettype wire

/* hdl/psram_defs.svh */
/*
 * Widths, buffer depths, command codes and transfer bit counts for the
 * quad-SPI PSRAM memory port. Included by the package and by any module
 * that needs one of these constants.
 */
`ifndef PSRAM_DEFS_SVH
`define PSRAM_DEFS_SVH

// host side geometry is 8M words of 32 bits.
`define PSRAM_ADDR_W      23
`define PSRAM_DATA_W      32

`define REQ_FIFO_DEPTH    4
`define RSP_FIFO_DEPTH    4

// command codes as seen by the PSRAM part.
`define CMD_QUAD_WRITE    8'h38
`define CMD_QUAD_READ     8'hEB
`define CMD_WRITE         8'h02
`define CMD_READ          8'h03

`define READ_WAIT_CYCLES  6

// bits shifted per phase on the serial interface.
`define XFER_CMD_BITS     8
`define XFER_ADDR_BITS    24
`define XFER_BYTE_BITS    8
`define XFER_HALF_BITS    16
`define XFER_WORD_BITS    32

`endif
